// File: files.f
+incdir+hdl
hdl/trace_pkg.sv
hdl/trace_lane_pack.sv
hdl/fifo_counter.sv
hdl/trace_fifo_ram.sv
hdl/trace_fifo_ctrl.sv
hdl/trace_apb_regs.sv
hdl/trace_buffer_top.sv
verification/tb_trace_buffer.sv

// File: verification/tb_trace_buffer.sv
// Trace buffer testbench: directed tests against a reference queue model, with APB checks
`timescale 1ns/10ps
`include "trace_settings.svh"

module tb_trace_buffer import trace_pkg::*; ();

  localparam int MAX_CYCLES = 3000;   // All tests together run well under 700 cycles

  logic        clk;
  logic        rst_n;
  trace_word_t tw_in0;
  trace_word_t tw_in1;
  trace_word_t tw_in2;
  logic [2:0]  tw_vld;
  trace_word_t tw_out;
  logic        tw_out_vld;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // Reference model state
  trace_word_t exp_q [$];
  int          model_count = 0;
  logic        model_en = 1'b0;
  int          model_drop = 0;
  int          model_acc = 0;

  int     errors = 0;
  int     out_count = 0;          // Words seen on tw_out
  int     cycles = 0;
  integer seed;
  string  test_name = "none";

  trace_buffer_top trace_buffer_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run still going after %0d cycles in test %s", MAX_CYCLES, test_name);
      $display("Test FAILED");
      $finish;
    end
  end

  // Mirrors the FIFO at each edge from the inputs applied during the cycle before
  always @(posedge clk) begin : ref_model
    trace_word_t lane_w [3];
    trace_word_t offered [3];
    int n;
    int allow;
    int wr;
    int pop;
    if (!rst_n) begin
      model_count = 0;
      model_en    = 1'b0;
      model_drop  = 0;
      model_acc   = 0;
      exp_q.delete();
    end else begin
      lane_w[0] = tw_in0;
      lane_w[1] = tw_in1;
      lane_w[2] = tw_in2;
      n = 0;
      for (int i = 0; i < 3; i++) begin
        if (model_en && tw_vld[i]) begin
          offered[n] = lane_w[i];
          n++;
        end
      end
      pop = (model_count != 0);
      if (!pop)
        allow = 3;                                  // Empty FIFO takes everything
      else if (`FIFO_DEPTH - model_count >= 3)
        allow = 3;
      else if (`FIFO_DEPTH - model_count >= 2)
        allow = 2;
      else
        allow = 1;                                  // Slot freed by this cycle's pop
      wr = (n < allow) ? n : allow;
      for (int i = 0; i < wr; i++) begin
        exp_q.push_back(offered[i]);
      end
      model_count = model_count + wr - pop;
      if (psel && penable && pwrite && (paddr == `REG_CTRL)) begin
        model_en = pwdata[0];
      end
      if (psel && penable && pwrite && (paddr == `REG_CTRL) && pwdata[1]) begin
        model_drop = 0;
        model_acc  = 0;
      end else begin
        model_drop = (model_drop + n - wr > 16'hFFFF) ? 16'hFFFF : model_drop + n - wr;
        model_acc  = (model_acc + wr > 16'hFFFF) ? 16'hFFFF : model_acc + wr;
      end
    end
  end

  // Output monitor, checks every word against the model order
  always @(negedge clk) begin
    if (rst_n && tw_out_vld) begin
      out_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR %s: word %h came out with none expected", test_name, tw_out);
      end else begin
        compare_word(test_name, exp_q.pop_front(), tw_out);
      end
    end
  end

  task automatic compare_word(input string name, input trace_word_t exp, input trace_word_t act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_count(input string name, input fifo_cnt_t exp, input fifo_cnt_t act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic compare_stat(input string name, input stat_cnt_t exp, input stat_cnt_t act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic report(input string what);
    errors++;
    $display("ERROR %s: %s", test_name, what);
  endtask

  // Offers one cycle of trace words
  task automatic offer(input logic [2:0] vld, input trace_word_t w0, input trace_word_t w1,
                       input trace_word_t w2);
    @(posedge clk);
    tw_vld <= vld;
    tw_in0 <= w0;
    tw_in1 <= w1;
    tw_in2 <= w2;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      tw_vld <= '0;
    end
  endtask

  // Waits until the model is empty and the last word has left the DUT
  task automatic drain();
    idle(1);
    @(negedge clk);
    while (model_count != 0 || tw_out_vld) @(negedge clk);
    if (exp_q.size() != 0) report("expected words never appeared on tw_out");
  endtask

  task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    tw_vld  <= '0;
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) @(negedge clk);   // Access phase
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata, output logic err);
    apb_access(1'b0, addr, '0, rdata, err);
  endtask

  task automatic reset_test();
    logic [31:0] rdata;
    logic        err;
    test_name = "reset_state";
    apb_read(`REG_STATUS, rdata, err);
    compare_count(test_name, '0, rdata[4:0]);
    for (int i = 0; i < 5; i++) begin
      offer(3'b111, 36'hA_0000_0000 + i, 36'hB_0000_0000 + i, 36'hC_0000_0000 + i);
    end
    drain();
    apb_read(`REG_STATUS, rdata, err);
    compare_count(test_name, '0, rdata[4:0]);
    if (out_count != 0) report("words appeared on tw_out with the port disabled");
  endtask

  task automatic single_word_test();
    trace_word_t w;
    w = 36'h9_1234_5678;
    test_name = "single_word";
    apb_write(`REG_CTRL, 32'h1);
    drain();
    offer(3'b001, w, '0, '0);
    idle(1);                            // Write edge
    @(negedge clk);
    if (tw_out_vld) report("word appeared one cycle after the offer");
    @(negedge clk);
    if (!tw_out_vld) report("word missing two cycles after the offer");
    compare_word(test_name, w, tw_out);
    @(negedge clk);
    if (tw_out_vld) report("word shown for more than one cycle");
  endtask

  task automatic burst_test();
    logic [31:0] rdata;
    logic        err;
    int          start;
    test_name = "burst_three";
    start = out_count;
    offer(3'b111, 36'h1_1111_1111, 36'h2_2222_2222, 36'h3_3333_3333);
    apb_read(`REG_STATUS, rdata, err);  // Three in, one already out
    compare_count(test_name, 5'd2, rdata[4:0]);
    drain();
    if (out_count - start != 3) report("burst did not yield exactly three words");
  endtask

  task automatic random_fill_test();
    logic [31:0] rdata;
    logic        err;
    logic [2:0]  lanes;
    test_name = "random_fill";
    for (int i = 0; i < 200; i++) begin
      lanes = 3'($random(seed));
      offer(lanes, trace_word_t'({$random(seed), $random(seed)}),
            trace_word_t'({$random(seed), $random(seed)}),
            trace_word_t'({$random(seed), $random(seed)}));
    end
    drain();
    if (model_drop == 0) report("random traffic never filled the FIFO");
    apb_read(`REG_STATUS, rdata, err);
    compare_count(test_name, fifo_cnt_t'(model_count), rdata[4:0]);
    apb_read(`REG_OVERFLOW, rdata, err);
    compare_stat(test_name, stat_cnt_t'(model_drop), rdata[15:0]);
    apb_read(`REG_ACCEPTED, rdata, err);
    compare_stat(test_name, stat_cnt_t'(model_acc), rdata[15:0]);
  endtask

  task automatic sparse_test();
    logic [2:0] pattern [6];
    int         start;
    int         offered;
    pattern = '{3'b101, 3'b010, 3'b100, 3'b101, 3'b110, 3'b001};
    test_name = "sparse_lanes";
    start   = out_count;
    offered = 0;
    foreach (pattern[i]) begin
      offer(pattern[i], 36'hD_0000_0000 + 3 * i, 36'hD_0000_0001 + 3 * i,
            36'hD_0000_0002 + 3 * i);
      offered += $countones(pattern[i]);
    end
    drain();
    if (out_count - start != offered) report("sparse lanes lost or added words");
  endtask

  task automatic register_test();
    logic [31:0] rdata;
    logic        err;
    test_name = "registers";
    apb_write(`REG_CTRL, 32'h3);          // Keep enable, clear statistics
    apb_read(`REG_OVERFLOW, rdata, err);
    compare_stat(test_name, '0, rdata[15:0]);
    apb_read(`REG_ACCEPTED, rdata, err);
    compare_stat(test_name, '0, rdata[15:0]);
    // Offset past ACCEPTED wraps in the 4-bit address onto CTRL
    apb_read(4'(`REG_ACCEPTED + 4), rdata, err);
    if (err) report("pslverr on the wrapped CTRL offset");
    if (rdata[0] !== 1'b1) report("wrapped offset did not read the enable bit");
    for (int a = 0; a < 16; a++) begin
      apb_read(4'(a), rdata, err);
      if (err !== (a[1:0] != 2'b00)) begin
        report($sformatf("pslverr %b wrong for offset %h", err, a));
      end
    end
    apb_write(`REG_STATUS, 32'h1F);
    apb_read(`REG_STATUS, rdata, err);
    compare_count(test_name, fifo_cnt_t'(model_count), rdata[4:0]);
  endtask

  initial begin
    seed    = 32'h624433db;
    rst_n   = 1'b0;
    tw_in0  = '0;
    tw_in1  = '0;
    tw_in2  = '0;
    tw_vld  = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    reset_test();
    single_word_test();
    burst_test();
    random_fill_test();
    sparse_test();
    register_test();
    idle(2);
    $display("Errors: %0d, words out: %0d", errors, out_count);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/trace_buffer_top.sv
// Trace buffer top: lane packer, packing FIFO and APB register slave
`timescale 1ns/10ps

module trace_buffer_top import trace_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  trace_word_t tw_in0,
  input  trace_word_t tw_in1,
  input  trace_word_t tw_in2,
  input  logic [2:0]  tw_vld,
  output trace_word_t tw_out,
  output logic        tw_out_vld,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  trace_word_t slot0;
  trace_word_t slot1;
  trace_word_t slot2;
  trace_word_t rd_data;
  tm_cnt_t     input_tm_cnt;
  tm_cnt_t     wr_num;
  tm_cnt_t     drop_num;
  cnt_inc_t    fifo_cnt_inc;
  fifo_cnt_t   count;
  logic [3:0]  wr_ptr;
  logic [3:0]  rd_ptr;
  logic        empty;
  logic        ge2_free;
  logic        ge3_free;
  logic        enable;

  trace_lane_pack trace_lane_pack_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable       (enable),
    .tw_in0       (tw_in0),
    .tw_in1       (tw_in1),
    .tw_in2       (tw_in2),
    .tw_vld       (tw_vld),
    .slot0        (slot0),
    .slot1        (slot1),
    .slot2        (slot2),
    .input_tm_cnt (input_tm_cnt)
  );

  fifo_counter fifo_counter_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .empty        (empty),
    .ge2_free     (ge2_free),
    .ge3_free     (ge3_free),
    .input_tm_cnt (input_tm_cnt),
    .fifo_cnt_inc (fifo_cnt_inc),
    .wr_num       (wr_num)
  );

  trace_fifo_ram trace_fifo_ram_i (
    .clk     (clk),
    .wr_ptr  (wr_ptr),
    .wr_num  (wr_num),
    .wd0     (slot0),
    .wd1     (slot1),
    .wd2     (slot2),
    .rd_ptr  (rd_ptr),
    .rd_data (rd_data)
  );

  trace_fifo_ctrl trace_fifo_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .fifo_cnt_inc (fifo_cnt_inc),
    .wr_num       (wr_num),
    .input_tm_cnt (input_tm_cnt),
    .rd_data      (rd_data),
    .empty        (empty),
    .ge2_free     (ge2_free),
    .ge3_free     (ge3_free),
    .count        (count),
    .wr_ptr       (wr_ptr),
    .rd_ptr       (rd_ptr),
    .drop_num     (drop_num),
    .tw_out       (tw_out),
    .tw_out_vld   (tw_out_vld)
  );

  trace_apb_regs trace_apb_regs_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .count    (count),
    .wr_num   (wr_num),
    .drop_num (drop_num),
    .enable   (enable)
  );

endmodule

// File: hdl/trace_apb_regs.sv
// Trace APB register slave: enable, fill level and saturating drop and accept counters
`timescale 1ns/10ps
`include "trace_settings.svh"

module trace_apb_regs import trace_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  fifo_cnt_t   count,
  input  tm_cnt_t     wr_num,
  input  tm_cnt_t     drop_num,
  output logic        enable
);

  stat_cnt_t overflow_cnt;
  stat_cnt_t accepted_cnt;
  logic      access;
  logic      mapped;
  logic      ctrl_wr;
  logic      stat_clr;

  // Adds a per-cycle count and sticks at all ones
  function automatic stat_cnt_t sat_add(input stat_cnt_t cnt, input tm_cnt_t inc);
    logic [16:0] sum;
    sum = {1'b0, cnt} + {15'd0, inc};
    return sum[16] ? '1 : sum[15:0];
  endfunction

  assign access = psel && penable;   // Access phase
  assign pready = 1'b1;              // Zero wait states

  always_comb begin
    case (reg_addr_t'(paddr))
      `REG_CTRL, `REG_STATUS, `REG_OVERFLOW, `REG_ACCEPTED: mapped = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  assign pslverr  = access && !mapped;
  assign ctrl_wr  = access && pwrite && (paddr == `REG_CTRL);
  assign stat_clr = ctrl_wr && pwdata[1];     // Self-clearing, never stored

  always_comb begin
    case (reg_addr_t'(paddr))
      `REG_CTRL:     prdata = {31'd0, enable};
      `REG_STATUS:   prdata = {27'd0, count};
      `REG_OVERFLOW: prdata = {16'd0, overflow_cnt};
      `REG_ACCEPTED: prdata = {16'd0, accepted_cnt};
      default:       prdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enable       <= 1'b0;
      overflow_cnt <= '0;
      accepted_cnt <= '0;
    end else begin
      if (ctrl_wr) begin
        enable <= pwdata[0];
      end
      if (stat_clr) begin                     // Clear beats this cycle's update
        overflow_cnt <= '0;
        accepted_cnt <= '0;
      end else begin
        overflow_cnt <= sat_add(overflow_cnt, drop_num);
        accepted_cnt <= sat_add(accepted_cnt, wr_num);
      end
    end
  end

  // APB access phase only follows a selected setup phase
  a_penable_psel: assert property (
    @(posedge clk) disable iff (!rst_n)
    penable |-> psel
  ) else $error("penable high without psel");

endmodule

// File: hdl/trace_fifo_ctrl.sv
// Trace FIFO controller: pointers, fill level, free-space flags and output register
`timescale 1ns/10ps
`include "trace_settings.svh"

module trace_fifo_ctrl import trace_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  cnt_inc_t    fifo_cnt_inc,
  input  tm_cnt_t     wr_num,
  input  tm_cnt_t     input_tm_cnt,
  input  trace_word_t rd_data,
  output logic        empty,
  output logic        ge2_free,
  output logic        ge3_free,
  output fifo_cnt_t   count,
  output logic [3:0]  wr_ptr,
  output logic [3:0]  rd_ptr,
  output tm_cnt_t     drop_num,
  output trace_word_t tw_out,
  output logic        tw_out_vld
);

  logic pop;

  // Flags come straight from the fill level
  assign empty    = (count == '0);
  assign ge2_free = (count <= fifo_cnt_t'(`FIFO_DEPTH - 2));
  assign ge3_free = (count <= fifo_cnt_t'(`FIFO_DEPTH - 3));

  assign pop = !empty;              // Output never stalls

  // Words the allowance refused this cycle
  assign drop_num = input_tm_cnt - wr_num;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      tw_out_vld <= 1'b0;
    end else begin
      wr_ptr     <= wr_ptr + {2'b00, wr_num};
      count      <= count + fifo_cnt_t'(fifo_cnt_inc);  // Two's complement wraps -1
      tw_out_vld <= pop;
      if (pop) begin
        rd_ptr <= rd_ptr + 4'd1;
      end
    end
  end

  // Head word is held for exactly one cycle
  always_ff @(posedge clk) begin
    if (pop) begin
      tw_out <= rd_data;
    end
  end

  a_count_max: assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= fifo_cnt_t'(`FIFO_DEPTH)
  ) else $error("FIFO count %0d above depth", count);

  // A word on the output must come from a FIFO whose pointers held data
  a_no_empty_pop: assert property (
    @(posedge clk) disable iff (!rst_n)
    tw_out_vld |-> $past((wr_ptr != rd_ptr) || count[4])
  ) else $error("tw_out_vld raised after an empty cycle");

  // Pointer distance tracks the fill level, counter and pointers stay in step
  a_ptr_count: assert property (
    @(posedge clk) disable iff (!rst_n)
    4'(wr_ptr - rd_ptr) == count[3:0]
  ) else $error("Pointer distance does not match count %0d", count);

endmodule

// File: hdl/trace_fifo_ram.sv
// Trace FIFO storage with up to three writes and one asynchronous read per cycle
`timescale 1ns/10ps
`include "trace_settings.svh"

module trace_fifo_ram import trace_pkg::*; (
  input  logic        clk,
  input  logic [3:0]  wr_ptr,
  input  tm_cnt_t     wr_num,
  input  trace_word_t wd0,
  input  trace_word_t wd1,
  input  trace_word_t wd2,
  input  logic [3:0]  rd_ptr,
  output trace_word_t rd_data
);

  trace_word_t mem [`FIFO_DEPTH];

  logic [3:0] wr_addr1;
  logic [3:0] wr_addr2;

  // Consecutive addresses, wrapping at the top entry
  assign wr_addr1 = wr_ptr + 4'd1;
  assign wr_addr2 = wr_ptr + 4'd2;

  always_ff @(posedge clk) begin
    if (wr_num >= 2'd1) begin
      mem[wr_ptr] <= wd0;
    end
    if (wr_num >= 2'd2) begin
      mem[wr_addr1] <= wd1;
    end
    if (wr_num == 2'd3) begin
      mem[wr_addr2] <= wd2;
    end
  end

  // Head of the queue, registered in the controller
  assign rd_data = mem[rd_ptr];

endmodule

// File: hdl/fifo_counter.sv
// FIFO counter: maps free space and offered words to the count change and write count
`timescale 1ns/10ps

module fifo_counter import trace_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     empty,
  input  logic     ge2_free,
  input  logic     ge3_free,
  input  tm_cnt_t  input_tm_cnt,
  output cnt_inc_t fifo_cnt_inc,
  output tm_cnt_t  wr_num
);

  cnt_inc_t wr_ext;

  // Write allowance, checked in priority order
  always_comb begin
    if (empty)
      wr_num = input_tm_cnt;                         // Nothing leaves, all words fit
    else if (ge3_free && (input_tm_cnt == 2'd3))
      wr_num = 2'd3;
    else if (ge2_free && (input_tm_cnt >= 2'd2))
      wr_num = 2'd2;
    else if (input_tm_cnt >= 2'd1)
      wr_num = 2'd1;                                 // Takes the slot being popped
    else
      wr_num = 2'd0;
  end

  assign wr_ext = cnt_inc_t'({3'b000, wr_num});

  // One word drains every cycle the FIFO holds data
  assign fifo_cnt_inc = empty ? wr_ext : (wr_ext - 5'sd1);

  // Known inputs never give an unknown result
  a_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown({empty, ge2_free, ge3_free, input_tm_cnt}) |->
      !$isunknown({fifo_cnt_inc, wr_num})
  ) else $error("fifo_cnt_inc or wr_num unknown with known inputs");

  a_legal_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    !empty |-> (fifo_cnt_inc inside {5'sd0, 5'sd1, 5'sd2, -5'sd1})
  ) else $error("Illegal fifo_cnt_inc %0d while not empty", fifo_cnt_inc);

  // With both flags set, a full burst takes the three-word path
  a_ge3_priority: assert property (
    @(posedge clk) disable iff (!rst_n)
    (!empty && ge3_free && ge2_free && (input_tm_cnt == 2'd3)) |->
      (fifo_cnt_inc == 5'sd2)
  ) else $error("ge3_free case lost to ge2_free, fifo_cnt_inc %0d", fifo_cnt_inc);

endmodule

// File: hdl/trace_lane_pack.sv
// Trace lane packer: moves valid lanes toward slot0 in lane order and counts them
`timescale 1ns/10ps

module trace_lane_pack import trace_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  trace_word_t tw_in0,
  input  trace_word_t tw_in1,
  input  trace_word_t tw_in2,
  input  logic [2:0]  tw_vld,
  output trace_word_t slot0,
  output trace_word_t slot1,
  output trace_word_t slot2,
  output tm_cnt_t     input_tm_cnt
);

  logic [2:0] vld_en;

  assign vld_en = enable ? tw_vld : 3'b000;   // Disabled port offers nothing

  always_comb begin
    slot0 = '0;
    slot1 = '0;
    slot2 = '0;
    case (vld_en)
      3'b001: slot0 = tw_in0;
      3'b010: slot0 = tw_in1;
      3'b100: slot0 = tw_in2;
      3'b011: begin
        slot0 = tw_in0;
        slot1 = tw_in1;
      end
      3'b101: begin                    // Gap on lane 1 closes up
        slot0 = tw_in0;
        slot1 = tw_in2;
      end
      3'b110: begin
        slot0 = tw_in1;
        slot1 = tw_in2;
      end
      3'b111: begin
        slot0 = tw_in0;
        slot1 = tw_in1;
        slot2 = tw_in2;
      end
      default: ;                       // No valid lane
    endcase
  end

  // Population count of the enabled valid bits
  assign input_tm_cnt = tm_cnt_t'({1'b0, vld_en[0]} + {1'b0, vld_en[1]} + {1'b0, vld_en[2]});

  // The count seen by the FIFO logic matches what the processor offered,
  // lane 0 always lands in slot0 and lane 2 in the last used slot
  a_cnt_popcount: assert property (
    @(posedge clk) disable iff (!rst_n)
    enable |-> ((input_tm_cnt == tm_cnt_t'($countones(tw_vld))) &&
                (!tw_vld[0] || (slot0 == tw_in0)) &&
                (!tw_vld[2] || (input_tm_cnt != 2'd1) || (slot0 == tw_in2)) &&
                (!tw_vld[2] || (input_tm_cnt != 2'd2) || (slot1 == tw_in2)) &&
                (!tw_vld[2] || (input_tm_cnt != 2'd3) || (slot2 == tw_in2)))
  ) else $error("input_tm_cnt %0d or slots do not match tw_vld %b", input_tm_cnt, tw_vld);

endmodule

// File: hdl/trace_pkg.sv
// Trace buffer package with the word, count and register types
`include "trace_settings.svh"

package trace_pkg;

  // One word from the trace port
  typedef logic [`TRACE_WIDTH-1:0] trace_word_t;

  // FIFO fill level, 0 up to FIFO_DEPTH
  typedef logic [4:0] fifo_cnt_t;

  // Per-cycle count change, two's complement, -1 .. +3
  typedef logic signed [4:0] cnt_inc_t;

  typedef logic [1:0] tm_cnt_t;      // Words offered or written in one cycle

  // Statistics counters stick at all ones
  typedef logic [15:0] stat_cnt_t;

  typedef logic [3:0] reg_addr_t;    // APB byte offset

endpackage

// File: hdl/trace_settings.svh
// Trace buffer settings: word width, FIFO depth and APB register offsets
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// Trace word as produced by the processor trace port
`define TRACE_WIDTH 36

// Packing FIFO entries, pointers are 4 bits wide
`define FIFO_DEPTH 16

// APB register byte offsets
`define REG_CTRL     4'h0
`define REG_STATUS   4'h4
`define REG_OVERFLOW 4'h8
`define REG_ACCEPTED 4'hC

`endif
